// File: src/split_fifo_pkg.sv
`default_nettype none

package split_fifo_pkg;

    // Entry field widths
    localparam int TAG_W = 8;
    localparam int PAYLOAD_W = 32;

    // Output register stages behind the M20K read address
    localparam int M20K_READ_LATENCY = 2;

    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [PAYLOAD_W-1:0] payload_t;

    // Tag sits in the upper bits
    typedef struct packed {
        tag_t tag;
        payload_t payload;
    } fifo_entry_t;

endpackage

`default_nettype wire

// File: src/mlab_memory.sv
`timescale 1ns/1ps
`default_nettype none

module mlab_memory
    import split_fifo_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    input wire clk,
    input wire rstReadAddr,

    // Write side
    input wire write_en,
    input wire [DEPTH_LOG2-1:0] write_addr,
    input wire tag_t tag_in,

    // Read side
    input wire read_stall,
    input wire [DEPTH_LOG2-1:0] read_addr,
    output tag_t tag_out
);

    tag_t memory [2**DEPTH_LOG2];

    logic [DEPTH_LOG2-1:0] write_addr_reg;
    tag_t write_data_reg;
    logic write_en_reg;
    logic [DEPTH_LOG2-1:0] read_addr_reg;

    // Write lands in the array one cycle after the strobe
    always_ff @(posedge clk) begin
        if (write_en_reg) begin
            memory[write_addr_reg] <= write_data_reg;
        end
        write_addr_reg <= write_addr;
        write_data_reg <= tag_in;
        write_en_reg <= write_en;
    end

    // MLAB address register clears asynchronously
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            read_addr_reg <= '0;
        end else if (!read_stall) begin
            read_addr_reg <= read_addr;
        end
    end

    // Unregistered read port
    assign tag_out = memory[read_addr_reg];

endmodule

`default_nettype wire

// File: src/m20k_memory.sv
`timescale 1ns/1ps
`default_nettype none

module m20k_memory
    import split_fifo_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    input wire clk,

    // Write side
    input wire write_en,
    input wire [DEPTH_LOG2-1:0] write_addr,
    input wire payload_t payload_in,

    // Read side
    input wire read_stall,
    input wire [DEPTH_LOG2-1:0] read_addr,
    output payload_t payload_out
);

    payload_t memory [2**DEPTH_LOG2];

    logic [DEPTH_LOG2-1:0] write_addr_reg;
    payload_t write_data_reg;
    logic write_en_reg;
    logic [DEPTH_LOG2-1:0] read_addr_reg;

    // Output stages, index 0 is next to the array
    payload_t read_pipe [M20K_READ_LATENCY];

    always_ff @(posedge clk) begin
        if (write_en_reg) begin
            memory[write_addr_reg] <= write_data_reg;
        end
        write_addr_reg <= write_addr;
        write_data_reg <= payload_in;
        write_en_reg <= write_en;
    end

    // No reset on the M20K address register
    always_ff @(posedge clk) begin
        if (!read_stall) begin
            read_addr_reg <= read_addr;
        end
    end

    // Stages run freely so reads can overlap
    always_ff @(posedge clk) begin
        read_pipe[0] <= memory[read_addr_reg];
        for (int i = 1; i < M20K_READ_LATENCY; i++) begin
            read_pipe[i] <= read_pipe[i-1];
        end
    end

    assign payload_out = read_pipe[M20K_READ_LATENCY-1];

endmodule

`default_nettype wire

// File: src/fifo_pointer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_pointer_ctrl
    import split_fifo_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    input wire clk,
    input wire rstReadAddr,

    // Producer handshake
    input wire push_req,
    input wire fifo_entry_t push_entry,
    output logic push_ack,

    // Consumer handshake
    input wire pop_req,
    input wire pop_done,

    // Memory write strobes
    output logic write_en,
    output logic [DEPTH_LOG2-1:0] write_addr,
    output fifo_entry_t write_entry,

    // Memory read strobes
    output logic [DEPTH_LOG2-1:0] read_addr,
    output logic read_stall,
    output logic read_issue
);

    localparam int DEPTH = 2**DEPTH_LOG2;

    typedef enum logic [1:0] {
        PUSH_IDLE,
        PUSH_WRITE,
        PUSH_ACK
    } push_state_t;

    typedef enum logic {
        POP_IDLE,
        POP_WAIT_DATA
    } pop_state_t;

    push_state_t push_state;
    pop_state_t pop_state;

    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0] occupancy;
    logic [DEPTH_LOG2:0] readable;
    logic [1:0] write_pipe;

    logic push_accept;
    logic pop_accept;
    logic read_strobe;

    assign push_accept = (push_state == PUSH_IDLE) && push_req &&
                         (occupancy < (DEPTH_LOG2+1)'(DEPTH));
    assign pop_accept = (pop_state == POP_IDLE) && pop_req && (readable != '0);
    assign read_strobe = !read_stall;

    assign push_ack = (push_state == PUSH_ACK);
    assign write_en = (push_state == PUSH_WRITE);
    assign write_addr = wr_ptr;
    assign read_addr = rd_ptr;

    // Push side
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            push_state <= PUSH_IDLE;
            wr_ptr <= '0;
        end else begin
            case (push_state)
                PUSH_IDLE: begin
                    if (push_accept) begin
                        push_state <= PUSH_WRITE;
                    end
                end
                PUSH_WRITE: begin
                    wr_ptr <= wr_ptr + 1'b1;
                    push_state <= PUSH_ACK;
                end
                PUSH_ACK: begin
                    if (!push_req) begin
                        push_state <= PUSH_IDLE;
                    end
                end
                default: push_state <= PUSH_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_accept) begin
            write_entry <= push_entry;
        end
    end

    // Pop side, one read in flight at a time
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            pop_state <= POP_IDLE;
            read_stall <= 1'b1;
            read_issue <= 1'b0;
            rd_ptr <= '0;
        end else begin
            read_stall <= !pop_accept;
            // Marks the edge where the memories take the address
            read_issue <= read_strobe;
            if (read_strobe) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case (pop_state)
                POP_IDLE: begin
                    if (pop_accept) begin
                        pop_state <= POP_WAIT_DATA;
                    end
                end
                POP_WAIT_DATA: begin
                    if (pop_done) begin
                        pop_state <= POP_IDLE;
                    end
                end
                default: pop_state <= POP_IDLE;
            endcase
        end
    end

    // Slot is freed once its read address is captured
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            occupancy <= '0;
        end else if (push_accept && !read_strobe) begin
            occupancy <= occupancy + 1'b1;
        end else if (!push_accept && read_strobe) begin
            occupancy <= occupancy - 1'b1;
        end
    end

    // Readable count trails writes by the memory write register
    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            write_pipe <= '0;
            readable <= '0;
        end else begin
            write_pipe <= {write_pipe[0], write_en};
            if (write_pipe[1] && !pop_accept) begin
                readable <= readable + 1'b1;
            end else if (!write_pipe[1] && pop_accept) begin
                readable <= readable - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/entry_merge.sv
`timescale 1ns/1ps
`default_nettype none

module entry_merge
    import split_fifo_pkg::*;
(
    input wire clk,
    input wire rstReadAddr,

    // From the memories
    input wire tag_t tag_in,
    input wire payload_t payload_in,

    // From the controller
    input wire read_issue,

    // Consumer handshake
    input wire pop_req,
    output fifo_entry_t pop_entry,
    output logic pop_ack,
    output logic pop_done
);

    // The MLAB tag is ready while the M20K payload is still in its stages
    tag_t tag_pipe [M20K_READ_LATENCY];
    logic [M20K_READ_LATENCY-1:0] issue_pipe;

    logic entry_arrives;

    assign entry_arrives = issue_pipe[M20K_READ_LATENCY-1];

    always_ff @(posedge clk) begin
        tag_pipe[0] <= tag_in;
        for (int i = 1; i < M20K_READ_LATENCY; i++) begin
            tag_pipe[i] <= tag_pipe[i-1];
        end
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            issue_pipe <= '0;
        end else begin
            issue_pipe <= {issue_pipe[M20K_READ_LATENCY-2:0], read_issue};
        end
    end

    // Joined entry holds until the next read arrives
    always_ff @(posedge clk) begin
        if (entry_arrives) begin
            pop_entry.tag <= tag_pipe[M20K_READ_LATENCY-1];
            pop_entry.payload <= payload_in;
        end
    end

    always_ff @(posedge clk or posedge rstReadAddr) begin
        if (rstReadAddr) begin
            pop_ack <= 1'b0;
            pop_done <= 1'b0;
        end else begin
            pop_done <= 1'b0;
            if (entry_arrives) begin
                pop_ack <= 1'b1;
            end else if (pop_ack && !pop_req) begin
                // Ends the pop in the controller
                pop_ack <= 1'b0;
                pop_done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/split_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module split_fifo_top
    import split_fifo_pkg::*;
#(
    parameter int DEPTH_LOG2 = 4
) (
    input wire clk,
    input wire rstReadAddr,

    input wire push_req,
    input wire fifo_entry_t push_entry,
    output logic push_ack,

    input wire pop_req,
    output fifo_entry_t pop_entry,
    output logic pop_ack
);

    logic write_en;
    logic [DEPTH_LOG2-1:0] write_addr;
    fifo_entry_t write_entry;
    logic [DEPTH_LOG2-1:0] read_addr;
    logic read_stall;
    logic read_issue;
    logic pop_done;
    tag_t tag_rd;
    payload_t payload_rd;

    fifo_pointer_ctrl #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) fifo_pointer_ctrl_i (
        .clk(clk),
        .rstReadAddr(rstReadAddr),
        .push_req(push_req),
        .push_entry(push_entry),
        .push_ack(push_ack),
        .pop_req(pop_req),
        .pop_done(pop_done),
        .write_en(write_en),
        .write_addr(write_addr),
        .write_entry(write_entry),
        .read_addr(read_addr),
        .read_stall(read_stall),
        .read_issue(read_issue)
    );

    // Tag and payload share addresses and strobes
    mlab_memory #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) mlab_memory_i (
        .clk(clk),
        .rstReadAddr(rstReadAddr),
        .write_en(write_en),
        .write_addr(write_addr),
        .tag_in(write_entry.tag),
        .read_stall(read_stall),
        .read_addr(read_addr),
        .tag_out(tag_rd)
    );

    m20k_memory #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) m20k_memory_i (
        .clk(clk),
        .write_en(write_en),
        .write_addr(write_addr),
        .payload_in(write_entry.payload),
        .read_stall(read_stall),
        .read_addr(read_addr),
        .payload_out(payload_rd)
    );

    entry_merge entry_merge_i (
        .clk(clk),
        .rstReadAddr(rstReadAddr),
        .tag_in(tag_rd),
        .payload_in(payload_rd),
        .read_issue(read_issue),
        .pop_req(pop_req),
        .pop_entry(pop_entry),
        .pop_ack(pop_ack),
        .pop_done(pop_done)
    );

endmodule

`default_nettype wire

// File: sim/split_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module split_fifo_tb
    import split_fifo_pkg::*;
();

    localparam int DEPTH_LOG2 = 4;
    localparam int DEPTH = 2**DEPTH_LOG2;
    localparam int CLK_PERIOD = 100;
    localparam int RANDOM_OPS = 150;
    // Pushes and pops of all tests together
    localparam int TOTAL_OPS = 2 + 2 * (DEPTH + 1) + 2 + 16 + 2 * RANDOM_OPS;
    localparam int LIMIT_CYCLES = TOTAL_OPS * 20 + 4;

    logic clk = 1'b0;
    logic rstReadAddr;
    logic push_req;
    fifo_entry_t push_entry;
    logic push_ack;
    logic pop_req;
    fifo_entry_t pop_entry;
    logic pop_ack;

    fifo_entry_t model [$];
    logic [31:0] rng_state = 32'h33ff_97bd;
    int errors = 0;
    int errors_at_start = 0;
    int tests_run = 0;
    int tests_failed = 0;
    fifo_entry_t rand_entries [RANDOM_OPS];
    int push_gap [RANDOM_OPS];
    int pop_gap [RANDOM_OPS];

    split_fifo_top #(
        .DEPTH_LOG2(DEPTH_LOG2)
    ) split_fifo_top_i (
        .clk(clk),
        .rstReadAddr(rstReadAddr),
        .push_req(push_req),
        .push_entry(push_entry),
        .push_ack(push_ack),
        .pop_req(pop_req),
        .pop_entry(pop_entry),
        .pop_ack(pop_ack)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic flag_violation(input string what);
        errors++;
        $display("At %0t ns: %s", $time, what);
    endtask

    // Handshake rules
    assert property (@(posedge clk) disable iff (rstReadAddr)
        (pop_ack && $past(pop_ack)) |-> $stable(pop_entry))
        else flag_violation("pop_entry changed while pop_ack was high");
    assert property (@(posedge clk) disable iff (rstReadAddr) $rose(push_ack) |-> $past(push_req))
        else flag_violation("push_ack rose without push_req");
    assert property (@(posedge clk) disable iff (rstReadAddr) $rose(pop_ack) |-> $past(pop_req))
        else flag_violation("pop_ack rose without pop_req");
    assert property (@(posedge clk) disable iff (rstReadAddr) $fell(push_ack) |-> !$past(push_req))
        else flag_violation("push_ack fell while push_req was still high");
    assert property (@(posedge clk) disable iff (rstReadAddr) $fell(pop_ack) |-> !$past(pop_req))
        else flag_violation("pop_ack fell while pop_req was still high");

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Tag and payload come from separate draws
    function automatic fifo_entry_t random_entry();
        fifo_entry_t e;
        logic [31:0] r;
        r = next_rand();
        e.tag = r[TAG_W-1:0];
        e.payload = next_rand();
        return e;
    endfunction

    task automatic expect_equal(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        assert (actual === expected)
        else begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic push_one(input fifo_entry_t entry);
        push_entry = entry;
        push_req = 1'b1;
        do step(); while (!push_ack);
        model.push_back(entry);
        push_req = 1'b0;
        do step(); while (push_ack);
    endtask

    // Expects pop_req already high, counts the cycles until pop_ack
    task automatic pop_finish(output int waited);
        fifo_entry_t expected;
        waited = 0;
        while (!pop_ack) begin
            step();
            waited++;
        end
        if (model.size() == 0) begin
            flag_violation("pop_ack with no entry left in the reference queue");
        end else begin
            expected = model.pop_front();
            expect_equal("pop_entry.tag", expected.tag, pop_entry.tag);
            expect_equal("pop_entry.payload", expected.payload, pop_entry.payload);
        end
        pop_req = 1'b0;
        do step(); while (pop_ack);
    endtask

    task automatic pop_one(output int waited);
        pop_req = 1'b1;
        pop_finish(waited);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        int waited;
        int pop_waited;
        fifo_entry_t entry;
        rstReadAddr = 1'b1;
        push_req = 1'b0;
        pop_req = 1'b0;
        push_entry = '0;
        // Reset covers the first four rising edges
        for (int i = 0; i < 7; i++) begin
            step();
            if (i == 3) rstReadAddr = 1'b0;
            expect_equal("push_ack", 0, push_ack);
            expect_equal("pop_ack", 0, pop_ack);
        end
        finish_test("reset");

        push_one(random_entry());
        repeat (2) step();
        pop_one(waited);
        // One edge to accept, four more to pop_ack
        expect_equal("pop_ack latency", 5, waited);
        finish_test("single entry");

        for (int i = 0; i < DEPTH; i++) push_one(random_entry());
        entry = random_entry();
        push_entry = entry;
        push_req = 1'b1;
        repeat (8) begin
            step();
            expect_equal("push_ack", 0, push_ack);
        end
        pop_one(waited);
        while (!push_ack) step();
        model.push_back(entry);
        push_req = 1'b0;
        do step(); while (push_ack);
        for (int i = 0; i < DEPTH; i++) pop_one(waited);
        finish_test("full fifo");

        pop_req = 1'b1;
        repeat (8) begin
            step();
            expect_equal("pop_ack", 0, pop_ack);
        end
        push_one(random_entry());
        pop_finish(waited);
        finish_test("empty fifo");

        for (int i = 0; i < 8; i++) push_one(random_entry());
        for (int i = 0; i < 8; i++) pop_one(waited);
        finish_test("field alignment");

        // Drawn up front so both sides see a fixed sequence
        for (int i = 0; i < RANDOM_OPS; i++) begin
            rand_entries[i] = random_entry();
            push_gap[i] = int'(next_rand() % 32'd4);
            pop_gap[i] = int'(next_rand() % 32'd8);
        end
        fork
            for (int i = 0; i < RANDOM_OPS; i++) begin
                repeat (push_gap[i]) step();
                push_one(rand_entries[i]);
            end
            for (int i = 0; i < RANDOM_OPS; i++) begin
                repeat (pop_gap[i]) step();
                pop_one(pop_waited);
            end
        join
        expect_equal("reference queue size", 0, model.size());
        finish_test("random traffic");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // 20 cycles per operation plus reset
    initial begin
        #(LIMIT_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", LIMIT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
src/split_fifo_pkg.sv
src/mlab_memory.sv
src/m20k_memory.sv
src/fifo_pointer_ctrl.sv
src/entry_merge.sv
src/split_fifo_top.sv
sim/split_fifo_tb.sv

// File: Bender.yml
package:
  name: split_fifo

sources:
  - src/split_fifo_pkg.sv
  - src/mlab_memory.sv
  - src/m20k_memory.sv
  - src/fifo_pointer_ctrl.sv
  - src/entry_merge.sv
  - src/split_fifo_top.sv
  - target: simulation
    files:
      - sim/split_fifo_tb.sv
